//--- test/smc_patterns.txt
// mode, then w v_gs v_ds for channels 0 to 5, then expected out_n (all hex)
// mode bit 1 picks the three largest, bit 0 picks drain current over gm
// mode 01, every channel in saturation
1  3 3 7  3 4 7  3 2 1  6 5 4  1 7 6  2 3 2  02
1  7 7 7  7 6 5  5 5 6  4 4 3  7 5 7  2 6 7  10
1  7 4 5  7 4 5  7 4 5  7 4 5  7 4 5  7 4 5  15
1  7 1 0  7 1 0  7 1 0  7 1 0  7 1 0  7 1 0  00
// mode 11, triode and saturation mixed
3  7 7 2  5 6 3  3 4 5  7 5 1  6 7 6  2 3 0  2f
3  4 7 5  7 7 4  7 3 1  1 6 7  3 5 2  5 7 3  34
3  7 7 7  7 7 7  7 7 7  7 7 7  7 7 7  7 7 7  54
3  7 7 1  1 2 0  7 7 1  1 2 0  7 7 1  1 2 0  19
// modes 00 and 10, transconductance with plain average
0  7 7 2  5 6 3  3 4 5  7 5 1  6 7 6  2 3 0  03
2  7 7 2  5 6 3  3 4 5  7 5 1  6 7 6  2 3 0  0e
2  4 7 5  7 7 4  7 3 1  1 6 7  3 5 2  5 7 3  0d
0  4 7 5  7 7 4  7 3 1  1 6 7  3 5 2  5 7 3  03
2  7 7 7  7 7 7  7 7 7  7 7 7  7 7 7  7 7 7  1c
0  3 3 7  3 4 7  3 2 1  6 5 4  1 7 6  2 3 2  02
2  3 3 7  3 4 7  3 2 1  6 5 4  1 7 6  2 3 2  08
// group swap on earlier channel sets
1  7 7 2  5 6 3  3 4 5  7 5 1  6 7 6  2 3 0  07
3  3 3 7  3 4 7  3 2 1  6 5 4  1 7 6  2 3 2  0f
1  4 7 5  7 7 4  7 3 1  1 6 7  3 5 2  5 7 3  08
3  7 7 7  7 6 5  5 5 6  4 4 3  7 5 7  2 6 7  37
2  7 7 7  7 6 5  5 5 6  4 4 3  7 5 7  2 6 7  17
0  7 7 7  7 6 5  5 5 6  4 4 3  7 5 7  2 6 7  09
1  7 7 1  1 2 0  7 7 1  1 2 0  7 7 1  1 2 0  00
2  7 7 1  1 2 0  7 7 1  1 2 0  7 7 1  1 2 0  04

//--- all.f
verilog/smc_pkg.sv
verilog/smc_stage_if.sv
verilog/device_calc.sv
verilog/device_array.sv
verilog/sort_network.sv
verilog/group_average.sv
verilog/smc_top.sv
test/tb_smc.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_smc
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx -- '$(PASS)' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/tb_smc.sv
module tb_smc
    import smc_pkg::*;
();

    localparam int pat_cnt    = 23;
    localparam int pat_fields = 20;    // mode, 6 x (w, v_gs, v_ds), expected
    localparam int rnd_cnt    = 200;
    localparam int max_cycles = pat_cnt + rnd_cnt + 10;  // margin covers reset and flushes

    logic       clk;
    logic       arst_n;
    logic [1:0] mode;
    volt_t      w_in   [chan_cnt];
    volt_t      vgs_in [chan_cnt];
    volt_t      vds_in [chan_cnt];
    out_t       out_n;

    logic [7:0] pat_mem [pat_cnt*pat_fields];
    out_t       exp_q [$];    // expected results still in the pipeline

    int n_checks    = 0;
    int n_errs      = 0;
    int mark_checks = 0;
    int mark_errs   = 0;
    int cycle_cnt   = 0;

    smc_top UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .mode   (mode),
        .w_0 (w_in[0]), .v_gs_0 (vgs_in[0]), .v_ds_0 (vds_in[0]),
        .w_1 (w_in[1]), .v_gs_1 (vgs_in[1]), .v_ds_1 (vds_in[1]),
        .w_2 (w_in[2]), .v_gs_2 (vgs_in[2]), .v_ds_2 (vds_in[2]),
        .w_3 (w_in[3]), .v_gs_3 (vgs_in[3]), .v_ds_3 (vds_in[3]),
        .w_4 (w_in[4]), .v_gs_4 (vgs_in[4]), .v_ds_4 (vds_in[4]),
        .w_5 (w_in[5]), .v_gs_5 (vgs_in[5]), .v_ds_5 (vds_in[5]),
        .out_n  (out_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // expected out_n straight from the device equations
    function automatic out_t model_out(input logic [1:0] m, input dev_arr_t d);
        int vals [chan_cnt];
        int vgs, vds, wv, ov, id, gm, t, base, sum;
        for (int c = 0; c < chan_cnt; c++) begin
            vgs = int'(d[c].v_gs);
            vds = int'(d[c].v_ds);
            wv  = int'(d[c].w);
            ov  = vgs - 1;
            if (ov > vds) begin    // triode
                id = vds * (2 * ov - vds);
                gm = 2 * vds;
            end else begin
                id = ov * ov;
                gm = 2 * ov;
            end
            vals[c] = (m[0] ? id : gm) * wv / 3;
        end
        // bubble sort, largest first
        for (int i = 0; i < chan_cnt - 1; i++) begin
            for (int j = 0; j < chan_cnt - 1 - i; j++) begin
                if (vals[j] < vals[j+1]) begin
                    t         = vals[j];
                    vals[j]   = vals[j+1];
                    vals[j+1] = t;
                end
            end
        end
        base = m[1] ? 0 : 3;
        if (m[0])
            sum = (3 * vals[base] + 4 * vals[base+1] + 5 * vals[base+2]) / 12;
        else
            sum = (vals[base] + vals[base+1] + vals[base+2]) / 3;
        return out_t'(sum);
    endfunction

    task automatic check_out(input out_t exp, input out_t act);
        n_checks++;
        if (act !== exp) begin
            n_errs++;
            $display("ERR t=%0t out_n expected %0d got %0d", $time, exp, act);
        end
    endtask

    // drive one vector and check the one applied two cycles earlier
    task automatic apply_vec(input logic [1:0] m, input dev_arr_t d,
                             input out_t exp);
        out_t exp_head;
        @(posedge clk);
        mode <= m;
        for (int c = 0; c < chan_cnt; c++) begin
            w_in[c]   <= d[c].w;
            vgs_in[c] <= d[c].v_gs;
            vds_in[c] <= d[c].v_ds;
        end
        exp_q.push_back(exp);
        @(negedge clk);
        if (exp_q.size() == 3) begin
            exp_head = exp_q.pop_front();
            check_out(exp_head, out_n);
        end
    endtask

    task automatic flush_pipe();
        dev_arr_t idle;
        for (int c = 0; c < chan_cnt; c++)
            idle[c] = '{w: 3'd0, v_gs: 3'd1, v_ds: 3'd0};
        repeat (2) apply_vec(2'b00, idle, '0);
        exp_q.delete();
    endtask

    task automatic report_test(input string name);
        $display("test %-9s %0d checks, %0d errors", name,
                 n_checks - mark_checks, n_errs - mark_errs);
        mark_checks = n_checks;
        mark_errs   = n_errs;
    endtask

    task automatic run_patterns();
        logic [1:0] m;
        dev_arr_t   d;
        int         b;
        for (int k = 0; k < pat_cnt; k++) begin
            b = k * pat_fields;
            m = pat_mem[b][1:0];
            for (int c = 0; c < chan_cnt; c++) begin
                d[c].w    = pat_mem[b+1+3*c][2:0];
                d[c].v_gs = pat_mem[b+2+3*c][2:0];
                d[c].v_ds = pat_mem[b+3+3*c][2:0];
            end
            apply_vec(m, d, pat_mem[b+19]);    // back to back
        end
        flush_pipe();
        report_test("patterns");
    endtask

    task automatic run_random();
        logic [31:0] rng;
        logic [1:0]  m;
        dev_arr_t    d;
        rng = 32'd89;
        for (int k = 0; k < rnd_cnt; k++) begin
            rng = xorshift32(rng);
            m   = rng[1:0];
            for (int c = 0; c < chan_cnt; c++) begin
                rng       = xorshift32(rng);
                d[c].w    = rng[2:0];
                d[c].v_gs = volt_t'((rng >> 3) % 7 + 1);  // zero is illegal
                d[c].v_ds = rng[13:11];
            end
            if (k == 0) begin
                // largest reachable result
                m = 2'b11;
                for (int c = 0; c < chan_cnt; c++)
                    d[c] = '{w: 3'd7, v_gs: 3'd7, v_ds: 3'd7};
            end
            apply_vec(m, d, model_out(m, d));
        end
        flush_pipe();
        report_test("random");
    endtask

    initial begin
        arst_n = 1'b0;
        mode   = '0;
        for (int c = 0; c < chan_cnt; c++) begin
            w_in[c]   = '0;
            vgs_in[c] = 3'd1;
            vds_in[c] = '0;
        end
        $readmemh("test/smc_patterns.txt", pat_mem);
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_out('0, out_n);    // registers still cleared
        report_test("reset");
        run_patterns();
        run_random();
        $display("total %0d checks, %0d errors", n_checks, n_errs);
        if (n_errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog/smc_top.sv
module smc_top
    import smc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [1:0]  mode,
    input  volt_t       w_0, v_gs_0, v_ds_0,
    input  volt_t       w_1, v_gs_1, v_ds_1,
    input  volt_t       w_2, v_gs_2, v_ds_2,
    input  volt_t       w_3, v_gs_3, v_ds_3,
    input  volt_t       w_4, v_gs_4, v_ds_4,
    input  volt_t       w_5, v_gs_5, v_ds_5,
    output out_t        out_n
);

    dev_arr_t  devs;
    mode_t     mode_s;
    norm_arr_t sorted;

    // gather the flat ports into channel records
    assign devs[0] = '{w: w_0, v_gs: v_gs_0, v_ds: v_ds_0};
    assign devs[1] = '{w: w_1, v_gs: v_gs_1, v_ds: v_ds_1};
    assign devs[2] = '{w: w_2, v_gs: v_gs_2, v_ds: v_ds_2};
    assign devs[3] = '{w: w_3, v_gs: v_gs_3, v_ds: v_ds_3};
    assign devs[4] = '{w: w_4, v_gs: v_gs_4, v_ds: v_ds_4};
    assign devs[5] = '{w: w_5, v_gs: v_gs_5, v_ds: v_ds_5};

    assign mode_s = '{sel_max: mode[1], use_id: mode[0]};

    smc_stage_if stage_if ();

    device_array u_dev (      // stage 1, registered
        .clk    (clk),
        .arst_n (arst_n),
        .devs   (devs),
        .mode   (mode_s),
        .stage  (stage_if.src)
    );

    sort_network u_sort (
        .stage  (stage_if.dst),
        .sorted (sorted)
    );

    group_average u_avg (     // stage 2, registered
        .clk    (clk),
        .arst_n (arst_n),
        .stage  (stage_if.dst),
        .sorted (sorted),
        .out_n  (out_n)
    );

endmodule

//--- verilog/group_average.sv
module group_average
    import smc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    smc_stage_if.dst    stage,
    input  norm_arr_t   sorted,
    output out_t        out_n
);

    logic [out_w+1:0] hi_x;     // largest of the group
    logic [out_w+1:0] mid_x;
    logic [out_w+1:0] lo_x;     // smallest of the group
    logic [out_w+1:0] wsum;     // weighted sum reaches 1008
    out_t             avg_c;

    // pick the top or bottom half of the sorted list
    always_comb begin
        if (stage.mode.sel_max) begin
            hi_x  = (out_w+2)'(sorted[0]);
            mid_x = (out_w+2)'(sorted[1]);
            lo_x  = (out_w+2)'(sorted[2]);
        end else begin
            hi_x  = (out_w+2)'(sorted[3]);
            mid_x = (out_w+2)'(sorted[4]);
            lo_x  = (out_w+2)'(sorted[5]);
        end
    end

    always_comb begin
        if (stage.mode.use_id) begin
            // 3*hi + 4*mid + 5*lo
            wsum  = (hi_x << 1) + hi_x + (mid_x << 2) + (lo_x << 2) + lo_x;
            avg_c = out_t'(wsum / wavg_div);
        end else begin
            wsum  = hi_x + mid_x + lo_x;
            avg_c = out_t'(wsum / avg_div);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_n <= '0;
        else         out_n <= avg_c;
    end

    // the network must hand over a descending list
    for (genvar i = 0; i < chan_cnt - 1; i++) begin : g_order
        a_sorted : assert property (@(posedge clk) sorted[i] >= sorted[i+1])
            else $error("sort order broken at index %0d", i);
    end

endmodule

//--- verilog/sort_network.sv
module sort_network
    import smc_pkg::*;
(
    smc_stage_if.dst    stage,
    output norm_arr_t   sorted
);

    norm_arr_t n;

    // one compare-exchange, larger value ends up at index hi
    function automatic norm_arr_t cx(
        input norm_arr_t   v,
        input int unsigned hi,
        input int unsigned lo
    );
        norm_t t;
        if (v[hi] < v[lo]) begin
            t     = v[hi];
            v[hi] = v[lo];
            v[lo] = t;
        end
        return v;
    endfunction

    // twelve-comparator network for six inputs
    always_comb begin
        n = stage.norm;
        n = cx(n, 0, 5);
        n = cx(n, 1, 3);
        n = cx(n, 2, 4);
        n = cx(n, 1, 2);
        n = cx(n, 3, 4);
        n = cx(n, 0, 3);
        n = cx(n, 2, 5);
        n = cx(n, 0, 1);
        n = cx(n, 2, 3);
        n = cx(n, 4, 5);
        n = cx(n, 1, 2);
        n = cx(n, 3, 4);    // index 0 holds the maximum now
    end

    assign sorted = n;

endmodule

//--- verilog/device_array.sv
module device_array
    import smc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  dev_arr_t    devs,
    input  mode_t       mode,
    smc_stage_if.src    stage
);

    norm_arr_t norm_c;    // combinational normalized values

    for (genvar i = 0; i < chan_cnt; i++) begin : g_chan
        device_calc u_calc (
            .dev    (devs[i]),
            .use_id (mode.use_id),
            .norm   (norm_c[i])
        );

        // V_GS = 0 would wrap the overdrive term to 7
        a_vgs_nonzero : assert property (
            @(posedge clk) disable iff (!arst_n)
            devs[i].v_gs != '0
        ) else $error("channel %0d: v_gs of zero is not a legal input", i);
    end

    // stage-1 register, mode travels with its values
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage.norm <= '0;
            stage.mode <= '0;
        end else begin
            stage.norm <= norm_c;
            stage.mode <= mode;
        end
    end

endmodule

//--- verilog/device_calc.sv
module device_calc
    import smc_pkg::*;
(
    input  dev_in_t dev,
    input  logic    use_id,
    output norm_t   norm
);

    volt_t                vgs_m1;    // overdrive, V_GS - 1
    logic                 triode;
    volt_t                id_a;
    logic [volt_w:0]      id_b;
    logic [2*volt_w-1:0]  id_val;    // at most 36
    logic [volt_w:0]      gm_val;    // at most 12
    logic [2*volt_w-1:0]  dev_val;
    logic [norm_w:0]      scaled;    // W * value, at most 252

    assign vgs_m1 = dev.v_gs - 1'b1;
    assign triode = (vgs_m1 > dev.v_ds);

    // Id = A * B in both regions
    // triode: A = V_DS, B = 2(V_GS-1) - V_DS
    // saturation: A = B = V_GS-1
    always_comb begin
        if (triode) begin
            id_a = dev.v_ds;
            id_b = {vgs_m1, 1'b0} - dev.v_ds;
        end else begin
            id_a = vgs_m1;
            id_b = {1'b0, vgs_m1};
        end
    end

    assign id_val = (2*volt_w)'(id_a) * (2*volt_w)'(id_b);

    // gm is twice the same A term
    assign gm_val = {id_a, 1'b0};

    assign dev_val = use_id ? id_val : (2*volt_w)'(gm_val);

    assign scaled = (norm_w+1)'(dev.w) * (norm_w+1)'(dev_val);

    // floor division by 3
    assign norm = norm_t'(scaled / norm_div);

endmodule

//--- verilog/smc_stage_if.sv
interface smc_stage_if
    import smc_pkg::*;
();

    // registered stage-1 results, consumed combinationally by stage 2
    norm_arr_t norm;
    mode_t     mode;

    modport src (
        output norm,
        output mode
    );

    modport dst (
        input norm,
        input mode
    );

endinterface

//--- verilog/smc_pkg.sv
package smc_pkg;

    // channel count and field widths
    localparam int chan_cnt = 6;
    localparam int volt_w   = 3;
    localparam int norm_w   = 7;    // W * 36 / 3 tops out at 84
    localparam int out_w    = 8;

    // divisors for normalization and the two averages
    localparam int norm_div = 3;
    localparam int wavg_div = 12;   // 3 + 4 + 5
    localparam int avg_div  = 3;

    typedef logic [volt_w-1:0] volt_t;

    typedef struct packed {
        volt_t w;
        volt_t v_gs;
        volt_t v_ds;
    } dev_in_t;

    typedef dev_in_t [chan_cnt-1:0] dev_arr_t;

    typedef logic [norm_w-1:0] norm_t;
    typedef norm_t [chan_cnt-1:0] norm_arr_t;

    typedef struct packed {
        logic sel_max;  // 1: three largest, 0: three smallest
        logic use_id;   // 1: drain current, 0: transconductance
    } mode_t;

    typedef logic [out_w-1:0] out_t;

endpackage
